/* hw/rs_div_pkg.sv */
package rs_div_pkg;

    // instruction address
    parameter int PC_W = 32;

    // physical register tag
    parameter int TAG_W = 8;

    // divide operation code
    parameter int OP_W = 4;

    // operand and result data
    parameter int DATA_W = 32;

    // pc, rd, op and both operands as one word
    parameter int ISSUE_W = PC_W + TAG_W + OP_W + 2 * DATA_W;

endpackage

/* hw/rs_dispatch_if.sv */
`timescale 1ns/100ps

interface rs_dispatch_if #(
    parameter int NUM_ENTRIES = 8
);

    logic [rs_div_pkg::PC_W-1:0]   pc;
    logic [rs_div_pkg::TAG_W-1:0]  rd;
    logic [rs_div_pkg::OP_W-1:0]   op;
    logic [rs_div_pkg::TAG_W-1:0]  src1;
    logic [rs_div_pkg::TAG_W-1:0]  src2;
    logic [rs_div_pkg::DATA_W-1:0] data1;   // already bypassed
    logic [rs_div_pkg::DATA_W-1:0] data2;
    logic                          rdy1;
    logic                          rdy2;
    logic [NUM_ENTRIES-1:0]        wr;      // one-hot, at most one bit

    modport alloc (
        output pc, rd, op, src1, src2, data1, data2, rdy1, rdy2, wr
    );

    modport entry (
        input pc, rd, op, src1, src2, data1, data2, rdy1, rdy2, wr
    );

endinterface

/* hw/rs_slot_if.sv */
`timescale 1ns/100ps

interface rs_slot_if;

    logic                          busy;
    logic                          req;     // busy with both operands valid
    logic [rs_div_pkg::PC_W-1:0]   pc;
    logic [rs_div_pkg::TAG_W-1:0]  rd;
    logic [rs_div_pkg::OP_W-1:0]   op;
    logic [rs_div_pkg::DATA_W-1:0] data1;
    logic [rs_div_pkg::DATA_W-1:0] data2;
    logic                          grant;

    modport entry (
        output busy, req, pc, rd, op, data1, data2,
        input  grant
    );

    modport select (
        input  busy, req, pc, rd, op, data1, data2,
        output grant
    );

endinterface

/* hw/rs_alloc.sv */
`timescale 1ns/100ps

module rs_alloc #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  logic [rs_div_pkg::PC_W-1:0]   disp_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_rd,
    input  logic [rs_div_pkg::OP_W-1:0]   disp_op,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src1,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src2,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_data1,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_data2,
    input  logic                          disp_rdy1,
    input  logic                          disp_rdy2,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_data,
    input  logic                          ld_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  ld_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] ld_data,
    input  logic [NUM_ENTRIES-1:0]        busy,
    rs_dispatch_if.alloc                  dispatch
);

    logic [NUM_ENTRIES-1:0] free;
    logic [NUM_ENTRIES-1:0] low_free;
    logic                   accept;
    logic                   alu_hit1;
    logic                   alu_hit2;
    logic                   ld_hit1;
    logic                   ld_hit2;

    assign free     = ~busy;
    assign low_free = free & (~free + 1'b1);    // lowest set bit
    assign accept   = disp_valid && disp_ready;

    assign dispatch.wr = accept ? low_free : '0;

    // Registered ready. Entries freed by a grant at the same edge are not
    // counted, so ready can lag one cycle behind a grant but never promises
    // an entry that is not there.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            disp_ready <= 1'b1;
        end else begin
            disp_ready <= |(free & ~dispatch.wr);
        end
    end

    // same-cycle broadcast bypass
    assign alu_hit1 = !disp_rdy1 && alu_valid && (alu_tag == disp_src1);
    assign alu_hit2 = !disp_rdy2 && alu_valid && (alu_tag == disp_src2);
    assign ld_hit1  = !disp_rdy1 && ld_valid && (ld_tag == disp_src1);
    assign ld_hit2  = !disp_rdy2 && ld_valid && (ld_tag == disp_src2);

    assign dispatch.data1 = alu_hit1 ? alu_data : (ld_hit1 ? ld_data : disp_data1);   // alu first
    assign dispatch.data2 = alu_hit2 ? alu_data : (ld_hit2 ? ld_data : disp_data2);
    assign dispatch.rdy1  = disp_rdy1 || alu_hit1 || ld_hit1;
    assign dispatch.rdy2  = disp_rdy2 || alu_hit2 || ld_hit2;

    assign dispatch.pc   = disp_pc;
    assign dispatch.rd   = disp_rd;
    assign dispatch.op   = disp_op;
    assign dispatch.src1 = disp_src1;
    assign dispatch.src2 = disp_src2;

endmodule

/* hw/rs_entry.sv */
`timescale 1ns/100ps

module rs_entry #(
    parameter int ENTRY_ID = 0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_data,
    input  logic                          ld_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  ld_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] ld_data,
    rs_dispatch_if.entry                  dispatch,
    rs_slot_if.entry                      slot
);

    logic                          busy;
    logic                          rdy1;
    logic                          rdy2;
    logic [rs_div_pkg::PC_W-1:0]   pc;
    logic [rs_div_pkg::TAG_W-1:0]  rd;
    logic [rs_div_pkg::OP_W-1:0]   op;
    logic [rs_div_pkg::TAG_W-1:0]  src1;
    logic [rs_div_pkg::TAG_W-1:0]  src2;
    logic [rs_div_pkg::DATA_W-1:0] data1;
    logic [rs_div_pkg::DATA_W-1:0] data2;
    logic                          wr;
    logic                          alu_hit1;
    logic                          alu_hit2;
    logic                          ld_hit1;
    logic                          ld_hit2;

    assign wr = dispatch.wr[ENTRY_ID];

    // wakeup compares, only for operands still waiting
    assign alu_hit1 = busy && !rdy1 && alu_valid && (alu_tag == src1);
    assign alu_hit2 = busy && !rdy2 && alu_valid && (alu_tag == src2);
    assign ld_hit1  = busy && !rdy1 && ld_valid && (ld_tag == src1);
    assign ld_hit2  = busy && !rdy2 && ld_valid && (ld_tag == src2);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
            rdy1 <= 1'b0;
            rdy2 <= 1'b0;
        end else if (wr) begin
            busy <= 1'b1;
            rdy1 <= dispatch.rdy1;
            rdy2 <= dispatch.rdy2;
        end else begin
            if (slot.grant) begin
                busy <= 1'b0;
            end
            if (alu_hit1 || ld_hit1) begin
                rdy1 <= 1'b1;
            end
            if (alu_hit2 || ld_hit2) begin
                rdy2 <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            pc    <= dispatch.pc;
            rd    <= dispatch.rd;
            op    <= dispatch.op;
            src1  <= dispatch.src1;
            src2  <= dispatch.src2;
            data1 <= dispatch.data1;
            data2 <= dispatch.data2;
        end else begin
            data1 <= alu_hit1 ? alu_data : (ld_hit1 ? ld_data : data1);    // alu wins a tie
            data2 <= alu_hit2 ? alu_data : (ld_hit2 ? ld_data : data2);
        end
    end

    assign slot.busy  = busy;
    assign slot.req   = busy && rdy1 && rdy2;
    assign slot.pc    = pc;
    assign slot.rd    = rd;
    assign slot.op    = op;
    assign slot.data1 = data1;
    assign slot.data2 = data2;

endmodule

/* hw/rs_issue_select.sv */
`timescale 1ns/100ps

module rs_issue_select #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    rs_slot_if.select                     slot [NUM_ENTRIES],
    output logic [NUM_ENTRIES-1:0]        busy,
    output logic                          iss_valid,
    input  logic                          iss_ready,
    output logic [rs_div_pkg::PC_W-1:0]   iss_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  iss_rd,
    output logic [rs_div_pkg::OP_W-1:0]   iss_op,
    output logic [rs_div_pkg::DATA_W-1:0] iss_data1,
    output logic [rs_div_pkg::DATA_W-1:0] iss_data2
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [NUM_ENTRIES-1:0]        req;
    logic [NUM_ENTRIES-1:0]        grant;
    logic [rs_div_pkg::PC_W-1:0]   pc_a    [NUM_ENTRIES];
    logic [rs_div_pkg::TAG_W-1:0]  rd_a    [NUM_ENTRIES];
    logic [rs_div_pkg::OP_W-1:0]   op_a    [NUM_ENTRIES];
    logic [rs_div_pkg::DATA_W-1:0] data1_a [NUM_ENTRIES];
    logic [rs_div_pkg::DATA_W-1:0] data2_a [NUM_ENTRIES];
    logic [IDX_W-1:0]              head;
    logic [IDX_W-1:0]              sel;
    logic                          found;
    logic                          can_load;

    // interface arrays need constant indices
    for (genvar k = 0; k < NUM_ENTRIES; k++) begin : g_slot
        assign busy[k]       = slot[k].busy;
        assign req[k]        = slot[k].req;
        assign pc_a[k]       = slot[k].pc;
        assign rd_a[k]       = slot[k].rd;
        assign op_a[k]       = slot[k].op;
        assign data1_a[k]    = slot[k].data1;
        assign data2_a[k]    = slot[k].data2;
        assign slot[k].grant = grant[k];
    end

    assign can_load = !iss_valid || iss_ready;     // empty or draining

    // first requester at or after head, wrapping
    always_comb begin
        int k;
        found = 1'b0;
        sel   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            k = int'(head) + i;
            if (k >= NUM_ENTRIES) begin
                k = k - NUM_ENTRIES;
            end
            if (!found && req[k]) begin
                found = 1'b1;
                sel   = k[IDX_W-1:0];
            end
        end
    end

    always_comb begin
        grant = '0;
        if (found && can_load) begin
            grant[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iss_valid <= 1'b0;
            head      <= '0;
        end else if (can_load) begin
            iss_valid <= found;
            if (found) begin
                head <= (sel == IDX_W'(NUM_ENTRIES - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

    // output word holds while stalled
    always_ff @(posedge clk) begin
        if (can_load && found) begin
            iss_pc    <= pc_a[sel];
            iss_rd    <= rd_a[sel];
            iss_op    <= op_a[sel];
            iss_data1 <= data1_a[sel];
            iss_data2 <= data2_a[sel];
        end
    end

endmodule

/* hw/rs_div_top.sv */
`timescale 1ns/100ps

module rs_div_top #(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          disp_valid,
    output logic                          disp_ready,
    input  logic [rs_div_pkg::PC_W-1:0]   disp_pc,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_rd,
    input  logic [rs_div_pkg::OP_W-1:0]   disp_op,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src1,
    input  logic [rs_div_pkg::TAG_W-1:0]  disp_src2,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_data1,
    input  logic [rs_div_pkg::DATA_W-1:0] disp_data2,
    input  logic                          disp_rdy1,
    input  logic                          disp_rdy2,
    input  logic                          alu_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  alu_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] alu_data,
    input  logic                          ld_valid,
    input  logic [rs_div_pkg::TAG_W-1:0]  ld_tag,
    input  logic [rs_div_pkg::DATA_W-1:0] ld_data,
    output logic                          iss_valid,
    input  logic                          iss_ready,
    output logic [rs_div_pkg::PC_W-1:0]   iss_pc,
    output logic [rs_div_pkg::TAG_W-1:0]  iss_rd,
    output logic [rs_div_pkg::OP_W-1:0]   iss_op,
    output logic [rs_div_pkg::DATA_W-1:0] iss_data1,
    output logic [rs_div_pkg::DATA_W-1:0] iss_data2
);

    logic [NUM_ENTRIES-1:0] busy;

    rs_dispatch_if #(.NUM_ENTRIES(NUM_ENTRIES)) disp_bus ();
    rs_slot_if                                  slot_bus [NUM_ENTRIES] ();

    rs_alloc #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_alloc (
        .clk        (clk),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_ready (disp_ready),
        .disp_pc    (disp_pc),
        .disp_rd    (disp_rd),
        .disp_op    (disp_op),
        .disp_src1  (disp_src1),
        .disp_src2  (disp_src2),
        .disp_data1 (disp_data1),
        .disp_data2 (disp_data2),
        .disp_rdy1  (disp_rdy1),
        .disp_rdy2  (disp_rdy2),
        .alu_valid  (alu_valid),
        .alu_tag    (alu_tag),
        .alu_data   (alu_data),
        .ld_valid   (ld_valid),
        .ld_tag     (ld_tag),
        .ld_data    (ld_data),
        .busy       (busy),
        .dispatch   (disp_bus.alloc)
    );

    for (genvar k = 0; k < NUM_ENTRIES; k++) begin : g_entry
        rs_entry #(
            .ENTRY_ID (k)
        ) i_entry (
            .clk       (clk),
            .reset     (reset),
            .alu_valid (alu_valid),
            .alu_tag   (alu_tag),
            .alu_data  (alu_data),
            .ld_valid  (ld_valid),
            .ld_tag    (ld_tag),
            .ld_data   (ld_data),
            .dispatch  (disp_bus.entry),
            .slot      (slot_bus[k].entry)
        );
    end

    rs_issue_select #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_select (
        .clk       (clk),
        .reset     (reset),
        .slot      (slot_bus),
        .busy      (busy),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_pc    (iss_pc),
        .iss_rd    (iss_rd),
        .iss_op    (iss_op),
        .iss_data1 (iss_data1),
        .iss_data2 (iss_data2)
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;    // 10 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;    // released just after an edge, like the stimulus
    end

endmodule

/* tests/tb_rs_div_checks.svh */
task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic check_pc(input string what, input logic [rs_div_pkg::PC_W-1:0] exp,
                        input logic [rs_div_pkg::PC_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        stop_with_failure("wrong pc value");
    end
endtask

task automatic check_tag(input string what, input logic [rs_div_pkg::TAG_W-1:0] exp,
                         input logic [rs_div_pkg::TAG_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        stop_with_failure("wrong tag value");
    end
endtask

task automatic check_op(input string what, input logic [rs_div_pkg::OP_W-1:0] exp,
                        input logic [rs_div_pkg::OP_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        stop_with_failure("wrong op value");
    end
endtask

task automatic check_data(input string what, input logic [rs_div_pkg::DATA_W-1:0] exp,
                          input logic [rs_div_pkg::DATA_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        stop_with_failure("wrong data value");
    end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
        stop_with_failure("wrong control bit");
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
        $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        stop_with_failure("wrong cycle count");
    end
endtask

/* tests/tb_rs_div.sv */
`timescale 1ns/100ps

module tb_rs_div;

    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          reset;
    logic                          disp_valid;
    logic                          disp_ready;
    logic [rs_div_pkg::PC_W-1:0]   disp_pc;
    logic [rs_div_pkg::TAG_W-1:0]  disp_rd;
    logic [rs_div_pkg::OP_W-1:0]   disp_op;
    logic [rs_div_pkg::TAG_W-1:0]  disp_src1;
    logic [rs_div_pkg::TAG_W-1:0]  disp_src2;
    logic [rs_div_pkg::DATA_W-1:0] disp_data1;
    logic [rs_div_pkg::DATA_W-1:0] disp_data2;
    logic                          disp_rdy1;
    logic                          disp_rdy2;
    logic                          alu_valid;
    logic [rs_div_pkg::TAG_W-1:0]  alu_tag;
    logic [rs_div_pkg::DATA_W-1:0] alu_data;
    logic                          ld_valid;
    logic [rs_div_pkg::TAG_W-1:0]  ld_tag;
    logic [rs_div_pkg::DATA_W-1:0] ld_data;
    logic                          iss_valid;
    logic                          iss_ready;
    logic [rs_div_pkg::PC_W-1:0]   iss_pc;
    logic [rs_div_pkg::TAG_W-1:0]  iss_rd;
    logic [rs_div_pkg::OP_W-1:0]   iss_op;
    logic [rs_div_pkg::DATA_W-1:0] iss_data1;
    logic [rs_div_pkg::DATA_W-1:0] iss_data2;

    // expected issues, matched by pc
    logic [rs_div_pkg::PC_W-1:0]   exp_pc [$];
    logic [rs_div_pkg::TAG_W-1:0]  exp_rd [$];
    logic [rs_div_pkg::OP_W-1:0]   exp_op [$];
    logic [rs_div_pkg::DATA_W-1:0] exp_d1 [$];
    logic [rs_div_pkg::DATA_W-1:0] exp_d2 [$];

    string  test_name = "reset";
    int     cyc = 0;
    int     accept_cyc = 0;
    int     issue_cyc = 0;
    int     stall_left = 0;
    integer seed = 32'h1357_db2d;

    logic                          held;
    logic [rs_div_pkg::PC_W-1:0]   held_pc;
    logic [rs_div_pkg::TAG_W-1:0]  held_rd;
    logic [rs_div_pkg::OP_W-1:0]   held_op;
    logic [rs_div_pkg::DATA_W-1:0] held_d1;
    logic [rs_div_pkg::DATA_W-1:0] held_d2;

    `include "tb_rs_div_checks.svh"

    tb_clock_gen i_clock (.clk(clk), .reset(reset));

    rs_div_top #(.NUM_ENTRIES(8)) i_dut (.*);

    always @(posedge clk) cyc++;

    // transfers and stall hold, sampled mid-cycle
    always @(negedge clk) begin
        int idx;
        logic [rs_div_pkg::ISSUE_W-1:0] word;
        if (!reset) begin
            if (held) begin
                check_bit("iss_valid during stall", 1'b1, iss_valid);
                check_pc("pc during stall", held_pc, iss_pc);
                check_tag("rd during stall", held_rd, iss_rd);
                check_op("op during stall", held_op, iss_op);
                check_data("data1 during stall", held_d1, iss_data1);
                check_data("data2 during stall", held_d2, iss_data2);
            end
            held = iss_valid && !iss_ready;
            held_pc = iss_pc;
            held_rd = iss_rd;
            held_op = iss_op;
            held_d1 = iss_data1;
            held_d2 = iss_data2;
            if (iss_valid && iss_ready) begin
                idx = -1;
                foreach (exp_pc[i]) begin
                    if (idx < 0 && exp_pc[i] === iss_pc) idx = i;
                end
                if (idx < 0) begin
                    word = {iss_pc, iss_rd, iss_op, iss_data1, iss_data2};
                    $display("%s: issued word %h at pc %h was not expected",
                             test_name, word, iss_pc);
                    stop_with_failure("unexpected issue");
                end else begin
                    check_tag("rd", exp_rd[idx], iss_rd);
                    check_op("op", exp_op[idx], iss_op);
                    check_data("data1", exp_d1[idx], iss_data1);
                    check_data("data2", exp_d2[idx], iss_data2);
                    exp_pc.delete(idx);
                    exp_rd.delete(idx);
                    exp_op.delete(idx);
                    exp_d1.delete(idx);
                    exp_d2.delete(idx);
                    issue_cyc = cyc + 1;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        alu_valid  = 1'b0;
        ld_valid   = 1'b0;
        iss_ready  = (stall_left == 0);
        if (stall_left > 0) stall_left--;
    endtask

    task automatic dispatch_one();
        int n;
        n = 0;
        disp_valid = 1'b1;
        @(negedge clk);
        while (!disp_ready) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("timeout waiting for disp_ready");
            @(negedge clk);
        end
        accept_cyc = cyc + 1;
        next_cycle();
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_pc.size() != 0) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("timeout waiting for expected issues");
            next_cycle();
        end
    endtask

    task automatic wait_ready_high();
        int n;
        n = 0;
        @(negedge clk);
        while (!disp_ready) begin
            n++;
            if (n > TIMEOUT) stop_with_failure("timeout waiting for disp_ready to rise");
            @(negedge clk);
        end
        next_cycle();
    endtask

    initial begin
        int    fd;
        int    r;
        int    n;
        string kw;
        string line;
        logic  v;
        logic [rs_div_pkg::PC_W-1:0]   f_pc;
        logic [rs_div_pkg::TAG_W-1:0]  f_rd;
        logic [rs_div_pkg::OP_W-1:0]   f_op;
        logic [rs_div_pkg::DATA_W-1:0] f_d1;
        logic [rs_div_pkg::DATA_W-1:0] f_d2;

        disp_valid = 1'b0;
        disp_pc = '0;
        disp_rd = '0;
        disp_op = '0;
        disp_src1 = '0;
        disp_src2 = '0;
        disp_data1 = '0;
        disp_data2 = '0;
        disp_rdy1 = 1'b0;
        disp_rdy2 = 1'b0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_data = '0;
        ld_valid = 1'b0;
        ld_tag = '0;
        ld_data = '0;
        iss_ready = 1'b1;
        held = 1'b0;

        fd = $fopen("tests/rs_div_vectors.txt", "r");
        if (fd == 0) stop_with_failure("cannot open tests/rs_div_vectors.txt");
        @(negedge reset);

        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", kw);
            if (r != 1) break;
            case (kw)
                "#": r = $fgets(line, fd);
                "T": r = $fscanf(fd, "%s", test_name);
                "D": begin
                    r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", disp_pc, disp_rd,
                                disp_op, disp_src1, disp_src2, disp_data1, disp_data2,
                                disp_rdy1, disp_rdy2);
                    dispatch_one();
                end
                "E": begin
                    r = $fscanf(fd, "%h %h %h %h %h", f_pc, f_rd, f_op, f_d1, f_d2);
                    exp_pc.push_back(f_pc);
                    exp_rd.push_back(f_rd);
                    exp_op.push_back(f_op);
                    exp_d1.push_back(f_d1);
                    exp_d2.push_back(f_d2);
                end
                "A": r = $fscanf(fd, "%h %h %h", alu_valid, alu_tag, alu_data);
                "L": r = $fscanf(fd, "%h %h %h", ld_valid, ld_tag, ld_data);
                "S": begin
                    r = $fscanf(fd, "%d", stall_left);
                    iss_ready = 1'b0;
                end
                "I": begin
                    r = $fscanf(fd, "%d", n);
                    repeat (n) next_cycle();
                end
                "G": repeat ($unsigned($random(seed)) % 4) next_cycle();   // random gap
                "W": wait_drain();
                "K": begin
                    r = $fscanf(fd, "%d", n);
                    check_count("issue latency", n, issue_cyc - accept_cyc);
                end
                "R": begin
                    r = $fscanf(fd, "%h", v);
                    @(negedge clk);
                    check_bit("disp_ready", v, disp_ready);
                    next_cycle();
                end
                "U": wait_ready_high();
                default: stop_with_failure({"unknown record in vector file: ", kw});
            endcase
        end
        $fclose(fd);
        wait_drain();

        // nothing left to issue
        @(negedge clk);
        check_bit("iss_valid after drain", 1'b0, iss_valid);

        $display("Done: no errors");
        $finish;
    end

endmodule

/* compile.f */
hw/rs_div_pkg.sv
hw/rs_dispatch_if.sv
hw/rs_slot_if.sv
hw/rs_alloc.sv
hw/rs_entry.sv
hw/rs_issue_select.sv
hw/rs_div_top.sv
+incdir+tests
tests/tb_clock_gen.sv
tests/tb_rs_div.sv

/* tests/rs_div_vectors.txt */
# D pc rd op src1 src2 data1 data2 rdy1 rdy2 / E pc rd op data1 data2
# A|L valid tag data / S n stall / I n idle / G gap / W drain / K n latency / R v / U / T name
T ready_issue
E 100 21 3 0000002a 00000007
D 100 21 3 00 00 0000002a 00000007 1 1
W
K 2
G
T wakeup_alu
E 104 22 4 00000011 00000055
D 104 22 4 00 31 00000011 00000000 1 0
A 1 32 deadbeef
I 2
A 0 31 12345678
I 2
A 1 31 00000055
I 1
W
T wakeup_load
E 108 23 5 00000066 00000002
D 108 23 5 40 00 00000000 00000002 0 1
L 1 40 00000066
I 1
W
T bypass
E 10c 24 6 00000077 00000088
A 1 50 00000077
L 1 51 00000088
D 10c 24 6 50 51 00000000 00000000 0 0
W
T bypass_tie
E 110 25 7 000000aa 000000aa
A 1 52 000000aa
L 1 52 000000bb
D 110 25 7 52 52 00000000 00000000 0 0
W
G
T station_full
E 200 30 1 00000aaa 00000001
E 204 31 1 00000bbb 00000002
E 208 32 1 00000bbb 00000003
E 20c 33 1 00000bbb 00000004
E 210 34 1 00000bbb 00000005
E 214 35 1 00000bbb 00000006
E 218 36 1 00000bbb 00000007
E 21c 37 1 00000bbb 00000008
D 200 30 1 60 00 00000000 00000001 0 1
D 204 31 1 61 00 00000000 00000002 0 1
D 208 32 1 61 00 00000000 00000003 0 1
D 20c 33 1 61 00 00000000 00000004 0 1
D 210 34 1 61 00 00000000 00000005 0 1
D 214 35 1 61 00 00000000 00000006 0 1
D 218 36 1 61 00 00000000 00000007 0 1
D 21c 37 1 61 00 00000000 00000008 0 1
R 0
A 1 60 00000aaa
I 1
U
A 1 61 00000bbb
I 1
W
T stall
S 8
E 300 40 2 00000100 00000200
E 304 41 2 00000101 00000201
D 300 40 2 00 00 00000100 00000200 1 1
D 304 41 2 00 00 00000101 00000201 1 1
W
T back_to_back
E 400 50 9 00000001 00000010
E 404 51 9 00000002 00000020
E 408 52 9 00000003 00000030
D 400 50 9 00 00 00000001 00000010 1 1
D 404 51 9 00 00 00000002 00000020 1 1
D 408 52 9 00 00 00000003 00000030 1 1
W
